// File: compile.f
decode_pkg.sv
fetch_skid_buffer.sv
slot_decoder.sv
predict_check.sv
decode_stage.sv
tb_clock_gen.sv
decode_tb.sv

// File: decode_pkg.sv
// decode stage shared definitions: field widths, major opcodes, exception causes, FSM states
package decode_pkg;

  // instruction word and the two-word fetch bundle
  typedef logic [31:0] insn_t;
  typedef logic [63:0] bundle_t;
  // word-pair pc, bit 0 set when the bundle starts at the upper word
  typedef logic [29:0] vpc_t;
  typedef logic [31:0] imm_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [3:0]  excp_code_t;
  // btb branch type, zero is a conditional branch
  typedef logic [1:0]  btype_t;

  // scheduler fields below are listed msb first
  // alu class {alu-op, jal, jalr, lui, auipc}, one-hot
  typedef logic [4:0] alu_type_t;
  // {insn[30], funct3}, branches carry funct3 only
  typedef logic [3:0] alu_op_t;
  // in-order class {load, store, csr, fence}, one-hot
  typedef logic [3:0] ios_type_t;
  // flush forcing {csr write, mret, fence.i, wfi}
  typedef logic [3:0] special_t;
  // {writes dest, uses rs1, uses rs2}
  typedef logic [2:0] reg_props_t;

  // major opcodes, insn[6:2]
  localparam logic [4:0] OPC_LOAD     = 5'b00000;
  localparam logic [4:0] OPC_MISC_MEM = 5'b00011;
  localparam logic [4:0] OPC_OP_IMM   = 5'b00100;
  localparam logic [4:0] OPC_AUIPC    = 5'b00101;
  localparam logic [4:0] OPC_STORE    = 5'b01000;
  localparam logic [4:0] OPC_OP       = 5'b01100;
  localparam logic [4:0] OPC_LUI      = 5'b01101;
  localparam logic [4:0] OPC_BRANCH   = 5'b11000;
  localparam logic [4:0] OPC_JALR     = 5'b11001;
  localparam logic [4:0] OPC_JAL      = 5'b11011;
  localparam logic [4:0] OPC_SYSTEM   = 5'b11100;

  // exception causes raised by decode
  localparam excp_code_t EXC_ILLEGAL    = 4'd2;
  localparam excp_code_t EXC_BREAKPOINT = 4'd3;
  localparam excp_code_t EXC_ECALL_U    = 4'd8;
  localparam excp_code_t EXC_ECALL_M    = 4'd11;

  // btb correction sequencing
  typedef enum logic {
    CORR_IDLE,
    CORR_HOLD
  } corr_state_t;

endpackage

// File: decode_stage.sv
// decode stage: two RV32I slot decoders behind a skid buffer, registered toward the renamer
`timescale 1ns/1ns
module decode_stage (
  input  logic                   cpu_clk_i,
  input  logic                   reset_i,
  input  logic                   flush_i,
  input  logic                   priv_i,
  input  logic                   tw_i,
  input  logic                   icache_idle_i,
  input  logic                   valid_i,
  input  decode_pkg::bundle_t    instr_i,
  input  decode_pkg::vpc_t       vpc_i,
  input  logic                   fetch_excp_vld_i,
  input  decode_pkg::excp_code_t fetch_excp_code_i,
  input  logic                   btb_vld_i,
  input  logic                   btb_idx_i,
  input  logic                   btb_way_i,
  input  decode_pkg::btype_t     btb_btype_i,
  input  logic [1:0]             btb_pred_i,
  input  decode_pkg::vpc_t       btb_target_i,
  input  logic                   rn_busy_i,
  output logic                   busy_o,
  output logic                   valid_o,
  output logic                   slot1_valid_o,
  output decode_pkg::vpc_t       bundle_pc_o,
  output logic                   btb_vld_o,
  output logic                   btb_idx_o,
  output logic                   btb_way_o,
  output decode_pkg::btype_t     btb_btype_o,
  output logic [1:0]             btb_pred_o,
  output decode_pkg::vpc_t       btb_target_o,
  output logic                   corr_flush_o,
  output decode_pkg::vpc_t       corr_pc_o,
  output logic                   slot0_port_o,
  output decode_pkg::alu_type_t  slot0_alu_type_o,
  output decode_pkg::alu_op_t    slot0_alu_op_o,
  output decode_pkg::ios_type_t  slot0_ios_type_o,
  output logic [2:0]             slot0_ios_op_o,
  output decode_pkg::special_t   slot0_special_o,
  output decode_pkg::reg_idx_t   slot0_rs1_o,
  output decode_pkg::reg_idx_t   slot0_rs2_o,
  output decode_pkg::reg_idx_t   slot0_dest_o,
  output decode_pkg::imm_t       slot0_imm_o,
  output decode_pkg::reg_props_t slot0_reg_props_o,
  output logic                   slot0_excp_vld_o,
  output decode_pkg::excp_code_t slot0_excp_code_o,
  output logic                   slot1_port_o,
  output decode_pkg::alu_type_t  slot1_alu_type_o,
  output decode_pkg::alu_op_t    slot1_alu_op_o,
  output decode_pkg::ios_type_t  slot1_ios_type_o,
  output logic [2:0]             slot1_ios_op_o,
  output decode_pkg::special_t   slot1_special_o,
  output decode_pkg::reg_idx_t   slot1_rs1_o,
  output decode_pkg::reg_idx_t   slot1_rs2_o,
  output decode_pkg::reg_idx_t   slot1_dest_o,
  output decode_pkg::imm_t       slot1_imm_o,
  output decode_pkg::reg_props_t slot1_reg_props_o,
  output logic                   slot1_excp_vld_o,
  output decode_pkg::excp_code_t slot1_excp_code_o
);
  // bundle record: words, pc, btb target/type/pred/vld/idx/way, fetch exception
  localparam int REC_W = $bits(decode_pkg::bundle_t) + 2 * $bits(decode_pkg::vpc_t) +
                         $bits(decode_pkg::btype_t) + 2 + 3 + 1 +
                         $bits(decode_pkg::excp_code_t);

  logic [REC_W-1:0] rec_in;
  logic [REC_W-1:0] rec_out;
  logic s_valid, s_btb_vld, s_btb_idx, s_btb_way, s_excp_vld;
  decode_pkg::bundle_t s_instr;
  decode_pkg::vpc_t s_vpc, s_target;
  decode_pkg::btype_t s_btype;
  logic [1:0] s_pred;
  decode_pkg::excp_code_t s_excp_code;
  decode_pkg::insn_t slot0_insn;
  logic slot1_valid, consume, drop, stage_flush;

  logic d0_port, d1_port, d0_branch, d1_branch, d0_excp_vld, d1_excp_vld;
  decode_pkg::alu_type_t d0_alu_type, d1_alu_type;
  decode_pkg::alu_op_t d0_alu_op, d1_alu_op;
  decode_pkg::ios_type_t d0_ios_type, d1_ios_type;
  logic [2:0] d0_ios_op, d1_ios_op;
  decode_pkg::special_t d0_special, d1_special;
  decode_pkg::reg_idx_t d0_rs1, d1_rs1, d0_rs2, d1_rs2, d0_dest, d1_dest;
  decode_pkg::imm_t d0_imm, d1_imm;
  decode_pkg::reg_props_t d0_reg_props, d1_reg_props;
  decode_pkg::excp_code_t d0_excp_code, d1_excp_code;

  assign rec_in = {instr_i, vpc_i, btb_target_i, btb_btype_i, btb_pred_i, btb_vld_i,
                   btb_idx_i, btb_way_i, fetch_excp_vld_i, fetch_excp_code_i};
  assign {s_instr, s_vpc, s_target, s_btype, s_pred, s_btb_vld,
          s_btb_idx, s_btb_way, s_excp_vld, s_excp_code} = rec_out;

  // a correction flush empties the stage just like an external flush
  assign stage_flush = flush_i | corr_flush_o;
  assign consume     = s_valid & ~rn_busy_i;

  fetch_skid_buffer #(
    .DATA_W(REC_W)
  ) u_skid (
    .cpu_clk_i  (cpu_clk_i),
    .reset_i    (reset_i),
    .flush_i    (stage_flush),
    .in_valid_i (valid_i),
    .in_data_i  (rec_in),
    .out_ready_i(~rn_busy_i),
    .busy_o     (busy_o),
    .out_valid_o(s_valid),
    .out_data_o (rec_out)
  );

  // bundle starting at the upper word issues that word alone from slot 0
  assign slot0_insn = s_vpc[0] ? s_instr[63:32] : s_instr[31:0];

  // a taken slot 0 prediction leaving the pair kills slot 1
  assign slot1_valid = ~s_vpc[0] &
                       ~(s_btb_vld & ~s_btb_idx & ((s_btype != 2'b00) | s_pred[1]) &
                         (s_target != {s_vpc[29:1], 1'b1}));

  slot_decoder u_slot0 (
    .insn_i(slot0_insn), .priv_i(priv_i), .tw_i(tw_i),
    .fetch_excp_vld_i(s_excp_vld), .fetch_excp_code_i(s_excp_code),
    .port_o(d0_port), .is_branch_o(d0_branch), .alu_type_o(d0_alu_type),
    .alu_op_o(d0_alu_op), .ios_type_o(d0_ios_type), .ios_op_o(d0_ios_op),
    .special_o(d0_special), .rs1_o(d0_rs1), .rs2_o(d0_rs2), .dest_o(d0_dest),
    .imm_o(d0_imm), .reg_props_o(d0_reg_props),
    .excp_vld_o(d0_excp_vld), .excp_code_o(d0_excp_code)
  );

  slot_decoder u_slot1 (
    .insn_i(s_instr[63:32]), .priv_i(priv_i), .tw_i(tw_i),
    .fetch_excp_vld_i(s_excp_vld), .fetch_excp_code_i(s_excp_code),
    .port_o(d1_port), .is_branch_o(d1_branch), .alu_type_o(d1_alu_type),
    .alu_op_o(d1_alu_op), .ios_type_o(d1_ios_type), .ios_op_o(d1_ios_op),
    .special_o(d1_special), .rs1_o(d1_rs1), .rs2_o(d1_rs2), .dest_o(d1_dest),
    .imm_o(d1_imm), .reg_props_o(d1_reg_props),
    .excp_vld_o(d1_excp_vld), .excp_code_o(d1_excp_code)
  );

  predict_check u_check (
    .cpu_clk_i(cpu_clk_i), .reset_i(reset_i), .flush_i(flush_i),
    .icache_idle_i(icache_idle_i), .rn_busy_i(rn_busy_i), .consume_i(consume),
    .vpc_i(s_vpc), .btb_vld_i(s_btb_vld), .btb_idx_i(s_btb_idx),
    .slot1_valid_i(slot1_valid), .slot0_branch_i(d0_branch), .slot1_branch_i(d1_branch),
    .drop_o(drop), .corr_flush_o(corr_flush_o), .corr_pc_o(corr_pc_o)
  );

  always_ff @(posedge cpu_clk_i) begin
    if (reset_i || stage_flush) begin
      valid_o <= 1'b0;
    end else if (!rn_busy_i) begin
      valid_o <= s_valid & ~drop;
    end
  end

  // payload toward the renamer, held while it is busy
  always_ff @(posedge cpu_clk_i) begin
    if (!rn_busy_i) begin
      slot1_valid_o     <= slot1_valid;
      bundle_pc_o       <= s_vpc;
      btb_vld_o         <= s_btb_vld;
      btb_idx_o         <= s_btb_idx;
      btb_way_o         <= s_btb_way;
      btb_btype_o       <= s_btype;
      btb_pred_o        <= s_pred;
      btb_target_o      <= s_target;
      slot0_port_o      <= d0_port;
      slot0_alu_type_o  <= d0_alu_type;
      slot0_alu_op_o    <= d0_alu_op;
      slot0_ios_type_o  <= d0_ios_type;
      slot0_ios_op_o    <= d0_ios_op;
      slot0_special_o   <= d0_special;
      slot0_rs1_o       <= d0_rs1;
      slot0_rs2_o       <= d0_rs2;
      slot0_dest_o      <= d0_dest;
      slot0_imm_o       <= d0_imm;
      slot0_reg_props_o <= d0_reg_props;
      slot0_excp_vld_o  <= d0_excp_vld;
      slot0_excp_code_o <= d0_excp_code;
      slot1_port_o      <= d1_port;
      slot1_alu_type_o  <= d1_alu_type;
      slot1_alu_op_o    <= d1_alu_op;
      slot1_ios_type_o  <= d1_ios_type;
      slot1_ios_op_o    <= d1_ios_op;
      slot1_special_o   <= d1_special;
      slot1_rs1_o       <= d1_rs1;
      slot1_rs2_o       <= d1_rs2;
      slot1_dest_o      <= d1_dest;
      slot1_imm_o       <= d1_imm;
      slot1_reg_props_o <= d1_reg_props;
      slot1_excp_vld_o  <= d1_excp_vld;
      slot1_excp_code_o <= d1_excp_code;
    end
  end

endmodule

// File: decode_tb.sv
// decode stage testbench: random bundles, reference decode model and output scoreboard
`timescale 1ns/1ns
module decode_tb;
  localparam int N_BUNDLES = 600;
  localparam int MAX_CYCLES = 6000;

  typedef struct packed {
    logic port; logic [4:0] alu_type; logic [3:0] alu_op;
    logic [3:0] ios_type; logic [2:0] ios_op; logic [3:0] special;
    logic [4:0] rs1; logic [4:0] rs2; logic [4:0] dest; logic [31:0] imm;
    logic [2:0] props; logic ev; logic [3:0] ec;
  } dec_t;

  typedef struct packed {
    logic [63:0] instr; logic [29:0] vpc; logic [29:0] target; logic [1:0] btype;
    logic [1:0] pred; logic bvld; logic bidx; logic bway; logic ev; logic [3:0] ec;
  } rec_t;

  logic cpu_clk_i, reset_i, flush_i, priv_i, tw_i, icache_idle_i, valid_i;
  logic [63:0] instr_i;
  logic [29:0] vpc_i, btb_target_i, bundle_pc_o, btb_target_o, corr_pc_o;
  logic fetch_excp_vld_i, btb_vld_i, btb_idx_i, btb_way_i, rn_busy_i;
  logic [3:0] fetch_excp_code_i;
  logic [1:0] btb_btype_i, btb_pred_i, btb_btype_o, btb_pred_o;
  logic busy_o, valid_o, slot1_valid_o, btb_vld_o, btb_idx_o, btb_way_o, corr_flush_o;
  dec_t o0, o1;

  rec_t fifo[$];
  rec_t m_rec;
  dec_t m_d0, m_d1;
  logic m_valid, m_hold, m_s1v;
  logic [29:0] m_corr_pc;
  int n_accepted;
  int cycles;

  tb_clock_gen u_clk (.cpu_clk_o(cpu_clk_i), .reset_o(reset_i));

  decode_stage u_decode_stage (
    .cpu_clk_i(cpu_clk_i), .reset_i(reset_i), .flush_i(flush_i), .priv_i(priv_i),
    .tw_i(tw_i), .icache_idle_i(icache_idle_i), .valid_i(valid_i), .instr_i(instr_i),
    .vpc_i(vpc_i), .fetch_excp_vld_i(fetch_excp_vld_i),
    .fetch_excp_code_i(fetch_excp_code_i), .btb_vld_i(btb_vld_i), .btb_idx_i(btb_idx_i),
    .btb_way_i(btb_way_i), .btb_btype_i(btb_btype_i), .btb_pred_i(btb_pred_i),
    .btb_target_i(btb_target_i), .rn_busy_i(rn_busy_i), .busy_o(busy_o),
    .valid_o(valid_o), .slot1_valid_o(slot1_valid_o), .bundle_pc_o(bundle_pc_o),
    .btb_vld_o(btb_vld_o), .btb_idx_o(btb_idx_o), .btb_way_o(btb_way_o),
    .btb_btype_o(btb_btype_o), .btb_pred_o(btb_pred_o), .btb_target_o(btb_target_o),
    .corr_flush_o(corr_flush_o), .corr_pc_o(corr_pc_o),
    .slot0_port_o(o0.port), .slot0_alu_type_o(o0.alu_type), .slot0_alu_op_o(o0.alu_op),
    .slot0_ios_type_o(o0.ios_type), .slot0_ios_op_o(o0.ios_op),
    .slot0_special_o(o0.special), .slot0_rs1_o(o0.rs1), .slot0_rs2_o(o0.rs2),
    .slot0_dest_o(o0.dest), .slot0_imm_o(o0.imm), .slot0_reg_props_o(o0.props),
    .slot0_excp_vld_o(o0.ev), .slot0_excp_code_o(o0.ec),
    .slot1_port_o(o1.port), .slot1_alu_type_o(o1.alu_type), .slot1_alu_op_o(o1.alu_op),
    .slot1_ios_type_o(o1.ios_type), .slot1_ios_op_o(o1.ios_op),
    .slot1_special_o(o1.special), .slot1_rs1_o(o1.rs1), .slot1_rs2_o(o1.rs2),
    .slot1_dest_o(o1.dest), .slot1_imm_o(o1.imm), .slot1_reg_props_o(o1.props),
    .slot1_excp_vld_o(o1.ev), .slot1_excp_code_o(o1.ec)
  );

  task automatic check_field(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    if (exp !== act) begin
      $display("Mismatch %s expected %h actual %h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  // JAL, JALR and conditional branches are the words a btb hit may point at
  function automatic logic is_branch_word(logic [31:0] w);
    return w[6:2] == decode_pkg::OPC_JAL || w[6:2] == decode_pkg::OPC_JALR ||
           w[6:2] == decode_pkg::OPC_BRANCH;
  endfunction

  // RV32I decode of one word following the stage rules
  function automatic dec_t ref_decode(logic [31:0] w, logic priv, logic tw,
                                      logic fev, logic [3:0] fec);
    dec_t d;
    logic [4:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [31:0] ii;
    logic ecall, ebreak, mret, wfi, csr, sys, legal, trap;
    opc = w[6:2];
    f3 = w[14:12];
    f7 = w[31:25];
    ii = {{20{w[31]}}, w[31:20]};
    sys = opc == decode_pkg::OPC_SYSTEM;
    ecall = w == 32'h00000073;
    ebreak = w == 32'h00100073;
    mret = w == 32'h30200073;
    wfi = w == 32'h10500073;
    csr = sys && f3 != 3'd0 && f3 != 3'd4;
    case (opc)
      decode_pkg::OPC_LOAD: legal = f3 != 3'd3 && f3 != 3'd6 && f3 != 3'd7;
      decode_pkg::OPC_STORE: legal = f3 <= 3'd2;
      decode_pkg::OPC_OP: legal = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      decode_pkg::OPC_OP_IMM: begin
        if (f3 == 3'd1) legal = f7 == 7'h00;
        else if (f3 == 3'd5) legal = f7 == 7'h00 || f7 == 7'h20;
        else legal = 1'b1;
      end
      decode_pkg::OPC_BRANCH: legal = f3 != 3'd2 && f3 != 3'd3;
      decode_pkg::OPC_JALR: legal = f3 == 3'd0;
      decode_pkg::OPC_JAL, decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC,
      decode_pkg::OPC_MISC_MEM: legal = 1'b1;
      decode_pkg::OPC_SYSTEM: legal = ecall || ebreak || mret || wfi || csr;
      default: legal = 1'b0;
    endcase
    legal = legal && w[1:0] == 2'b11;
    d.port = opc == decode_pkg::OPC_LOAD || opc == decode_pkg::OPC_STORE || sys ||
             opc == decode_pkg::OPC_MISC_MEM;
    d.alu_type = {opc == decode_pkg::OPC_OP || opc == decode_pkg::OPC_OP_IMM,
                  opc == decode_pkg::OPC_JAL, opc == decode_pkg::OPC_JALR,
                  opc == decode_pkg::OPC_LUI, opc == decode_pkg::OPC_AUIPC};
    if (opc == decode_pkg::OPC_OP || (opc == decode_pkg::OPC_OP_IMM && f3 == 3'd5))
      d.alu_op = {w[30], f3};
    else
      d.alu_op = {1'b0, f3};
    d.ios_type = {opc == decode_pkg::OPC_LOAD, opc == decode_pkg::OPC_STORE, csr,
                  opc == decode_pkg::OPC_MISC_MEM && f3 == 3'd0};
    d.ios_op = f3;
    d.special = {csr && w[19:15] != 5'd0, mret,
                 opc == decode_pkg::OPC_MISC_MEM && f3 == 3'd1, wfi};
    d.rs1 = w[19:15];
    d.rs2 = w[24:20];
    d.dest = w[11:7];
    case (opc)
      decode_pkg::OPC_OP_IMM, decode_pkg::OPC_JALR, decode_pkg::OPC_LOAD: d.imm = ii;
      decode_pkg::OPC_SYSTEM: d.imm = {ii[31:13], w[19:15] != 5'd0, ii[11:0]};
      decode_pkg::OPC_STORE: d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
      decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC: d.imm = {w[31:12], 12'h000};
      decode_pkg::OPC_JAL: d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      decode_pkg::OPC_BRANCH: d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      default: d.imm = 32'h0;
    endcase
    d.props[2] = (d.alu_type != 5'd0 || opc == decode_pkg::OPC_LOAD || csr) &&
                 w[11:7] != 5'd0;
    d.props[1] = !(ecall || ebreak || mret || wfi || opc == decode_pkg::OPC_AUIPC ||
                   opc == decode_pkg::OPC_LUI || opc == decode_pkg::OPC_JAL);
    d.props[0] = opc == decode_pkg::OPC_OP || opc == decode_pkg::OPC_BRANCH ||
                 opc == decode_pkg::OPC_STORE;
    trap = !legal || (mret && !priv) || (wfi && !priv && tw);
    d.ev = fev || trap || ecall || ebreak;
    if (fev) d.ec = fec;
    else if (trap) d.ec = decode_pkg::EXC_ILLEGAL;
    else if (ecall) d.ec = priv ? decode_pkg::EXC_ECALL_M : decode_pkg::EXC_ECALL_U;
    else d.ec = decode_pkg::EXC_BREAKPOINT;
    return d;
  endfunction

  // one word from a pool of legal and illegal encodings of each class
  function automatic logic [31:0] gen_word();
    logic [31:0] w;
    w = $urandom;
    case ($urandom % 14)
      0: begin
        w[6:0] = 7'b0110011;
        if ($urandom % 4 != 0) w[31:25] = ($urandom % 2) ? 7'h00 : 7'h20;
      end
      1: begin
        w[6:0] = 7'b0010011;
        if ($urandom % 2) w[31:25] = ($urandom % 2) ? 7'h00 : 7'h20;
      end
      2: w[6:0] = 7'b0000011;
      3: w[6:0] = 7'b0100011;
      4: w[6:0] = 7'b1100011;
      5: w[6:0] = 7'b1101111;
      6: begin
        w[6:0] = 7'b1100111;
        if ($urandom % 4 != 0) w[14:12] = 3'd0;
      end
      7: w[6:0] = 7'b0110111;
      8: w[6:0] = 7'b0010111;
      9: w[6:0] = 7'b0001111;
      10: begin
        case ($urandom % 4)
          0: w = 32'h00000073;
          1: w = 32'h00100073;
          2: w = 32'h30200073;
          default: w = 32'h10500073;
        endcase
      end
      11: w[6:0] = 7'b1110011;
      12: w[1:0] = 2'b11;
      default: w[1:0] = 2'($urandom % 3);
    endcase
    return w;
  endfunction

  task automatic compare_outputs();
    check_field("slot1_valid_o", m_s1v, slot1_valid_o);
    check_field("bundle_pc_o", m_rec.vpc, bundle_pc_o);
    check_field("btb_target_o", m_rec.target, btb_target_o);
    check_field("btb_fields", {m_rec.btype, m_rec.pred, m_rec.bvld, m_rec.bidx, m_rec.bway},
                {btb_btype_o, btb_pred_o, btb_vld_o, btb_idx_o, btb_way_o});
    check_field("slot0_fields", 64'(m_d0 >> 45), 64'(o0 >> 45));
    check_field("slot0_imm_props_excp", 64'(m_d0[44:0]), 64'(o0[44:0]));
    if (m_s1v) begin
      check_field("slot1_fields", 64'(m_d1 >> 45), 64'(o1 >> 45));
      check_field("slot1_imm_props_excp", 64'(m_d1[44:0]), 64'(o1[44:0]));
    end
  endtask

  // scoreboard: models the buffer and correction FSM and compares on every edge
  always @(posedge cpu_clk_i) begin : scoreboard
    rec_t head;
    logic [31:0] w0, w1;
    logic cf_exp, mis, drop;
    dec_t d0, d1;
    if (reset_i) begin
      fifo.delete();
      m_valid = 1'b0;
      m_hold = 1'b0;
    end else begin
      cf_exp = m_hold && icache_idle_i && !flush_i && !rn_busy_i;
      check_field("valid_o", 64'(m_valid), 64'(valid_o));
      check_field("busy_o", 64'(fifo.size() == 2), 64'(busy_o));
      check_field("corr_flush_o", 64'(cf_exp), 64'(corr_flush_o));
      if (cf_exp) check_field("corr_pc_o", 64'(m_corr_pc), 64'(corr_pc_o));
      if (m_valid) compare_outputs();
      if (flush_i || cf_exp) begin
        fifo.delete();
        m_valid = 1'b0;
        m_hold = 1'b0;
      end else begin
        if (valid_i && fifo.size() < 2) begin
          fifo.push_back({instr_i, vpc_i, btb_target_i, btb_btype_i, btb_pred_i, btb_vld_i,
                          btb_idx_i, btb_way_i, fetch_excp_vld_i, fetch_excp_code_i});
          n_accepted++;
        end
        if (!rn_busy_i) begin
          if (fifo.size() > 0) begin
            head = fifo.pop_front();
            w0 = head.vpc[0] ? head.instr[63:32] : head.instr[31:0];
            w1 = head.instr[63:32];
            d0 = ref_decode(w0, priv_i, tw_i, head.ev, head.ec);
            d1 = ref_decode(w1, priv_i, tw_i, head.ev, head.ec);
            m_s1v = !head.vpc[0] && !(head.bvld && !head.bidx &&
                    (head.btype != 2'b00 || head.pred[1]) &&
                    head.target != {head.vpc[29:1], 1'b1});
            mis = head.bvld && ((!head.bidx && !is_branch_word(w0)) ||
                  (head.bidx && m_s1v && !is_branch_word(w1)));
            drop = mis || m_hold;
            if (!m_hold && mis) begin
              m_hold = 1'b1;
              m_corr_pc = head.vpc;
            end
            m_valid = !drop;
            m_rec = head;
            m_d0 = d0;
            m_d1 = d1;
          end else begin
            m_valid = 1'b0;
          end
        end
      end
    end
  end

  always @(posedge cpu_clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: bundles were not all accepted within the cycle limit");
      $display("TEST FAIL");
      $fatal(1);
    end
  end

  initial begin
    {flush_i, priv_i, tw_i, icache_idle_i, valid_i, instr_i, vpc_i} = '0;
    {fetch_excp_vld_i, fetch_excp_code_i, btb_vld_i, btb_idx_i, btb_way_i} = '0;
    {btb_btype_i, btb_pred_i, btb_target_i, rn_busy_i} = '0;
    n_accepted = 0;
    cycles = 0;
    void'($urandom(32'h0fa6a192));
    wait (!reset_i);
    while (n_accepted < N_BUNDLES) begin
      @(posedge cpu_clk_i);
      #10;
      valid_i = ($urandom % 4) != 0;
      instr_i = {gen_word(), gen_word()};
      vpc_i = 30'($urandom);
      fetch_excp_vld_i = ($urandom % 16) == 0;
      fetch_excp_code_i = 4'($urandom);
      btb_vld_i = ($urandom % 6) == 0;
      btb_idx_i = 1'($urandom);
      btb_way_i = 1'($urandom);
      btb_btype_i = 2'($urandom);
      btb_pred_i = 2'($urandom);
      btb_target_i = ($urandom % 2) ? {vpc_i[29:1], 1'b1} : 30'($urandom);
      rn_busy_i = ($urandom % 3) == 0;
      flush_i = ($urandom % 60) == 0;
      icache_idle_i = ($urandom % 4) != 0;
      if (($urandom % 32) == 0) priv_i = ~priv_i;
      if (($urandom % 32) == 0) tw_i = ~tw_i;
    end
    // drain what is still in flight, including a pending correction flush
    @(posedge cpu_clk_i);
    #10;
    valid_i = 1'b0;
    rn_busy_i = 1'b0;
    flush_i = 1'b0;
    icache_idle_i = 1'b1;
    while (fifo.size() != 0 || m_valid || m_hold) begin
      @(posedge cpu_clk_i);
      #10;
    end
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: fetch_skid_buffer.sv
// fetch skid buffer: two-entry queue that absorbs renamer back-pressure without a bubble
`timescale 1ns/1ns
module fetch_skid_buffer #(
  parameter int DATA_W = 136
) (
  input  logic              cpu_clk_i,
  input  logic              reset_i,
  input  logic              flush_i,
  input  logic              in_valid_i,
  input  logic [DATA_W-1:0] in_data_i,
  input  logic              out_ready_i,
  output logic              busy_o,
  output logic              out_valid_o,
  output logic [DATA_W-1:0] out_data_o
);
  logic              main_vld;
  logic [DATA_W-1:0] main_data;
  logic              skid_vld;
  logic [DATA_W-1:0] skid_data;
  logic              accept;
  logic              pop;
  logic              main_wr;
  logic              skid_wr;

  // an empty buffer passes the incoming bundle straight through
  assign out_valid_o = main_vld | in_valid_i;
  assign out_data_o  = main_vld ? main_data : in_data_i;
  assign busy_o      = skid_vld;

  assign accept  = in_valid_i & ~skid_vld;
  assign pop     = out_valid_o & out_ready_i;
  assign main_wr = main_vld ? pop : ~out_ready_i;
  assign skid_wr = main_vld & ~pop & accept;

  always_ff @(posedge cpu_clk_i) begin
    if (reset_i || flush_i) begin
      main_vld <= 1'b0;
      skid_vld <= 1'b0;
    end else if (main_vld) begin
      if (pop) begin
        // skid refills main first, keeping bundle order
        main_vld <= skid_vld | accept;
        skid_vld <= 1'b0;
      end else if (accept) begin
        skid_vld <= 1'b1;
      end
    end else begin
      main_vld <= accept & ~out_ready_i;
    end
  end

  always_ff @(posedge cpu_clk_i) begin
    if (main_wr) begin
      main_data <= skid_vld ? skid_data : in_data_i;
    end
    if (skid_wr) begin
      skid_data <= in_data_i;
    end
  end

  // a full skid entry always sits behind a full main entry
  a_skid_behind_main: assert property (@(posedge cpu_clk_i) disable iff (reset_i)
    skid_vld |-> main_vld);

  a_out_stable: assert property (@(posedge cpu_clk_i) disable iff (reset_i || flush_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

// File: predict_check.sv
// prediction check: catches BTB hits on non-branch slots and sequences the correction flush
`timescale 1ns/1ns
module predict_check (
  input  logic             cpu_clk_i,
  input  logic             reset_i,
  input  logic             flush_i,
  input  logic             icache_idle_i,
  input  logic             rn_busy_i,
  input  logic             consume_i,
  input  decode_pkg::vpc_t vpc_i,
  input  logic             btb_vld_i,
  input  logic             btb_idx_i,
  input  logic             slot1_valid_i,
  input  logic             slot0_branch_i,
  input  logic             slot1_branch_i,
  output logic             drop_o,
  output logic             corr_flush_o,
  output decode_pkg::vpc_t corr_pc_o
);
  decode_pkg::corr_state_t corr_state;
  logic pred0_bad;
  logic pred1_bad;
  logic mispredict;
  logic in_hold;

  // slot 1 predictions only count when slot 1 is really issued
  assign pred0_bad  = btb_vld_i & ~btb_idx_i & ~slot0_branch_i;
  assign pred1_bad  = btb_vld_i & btb_idx_i & slot1_valid_i & ~slot1_branch_i;
  assign mispredict = pred0_bad | pred1_bad;

  assign in_hold      = corr_state == decode_pkg::CORR_HOLD;
  assign drop_o       = mispredict | in_hold;
  assign corr_flush_o = in_hold & icache_idle_i & ~flush_i & ~rn_busy_i;

  always_ff @(posedge cpu_clk_i) begin
    if (reset_i || flush_i) begin
      corr_state <= decode_pkg::CORR_IDLE;
    end else begin
      case (corr_state)
        decode_pkg::CORR_IDLE: begin
          if (consume_i && mispredict) begin
            corr_state <= decode_pkg::CORR_HOLD;
          end
        end
        decode_pkg::CORR_HOLD: begin
          if (corr_flush_o) begin
            corr_state <= decode_pkg::CORR_IDLE;
          end
        end
        default: corr_state <= decode_pkg::CORR_IDLE;
      endcase
    end
  end

  // pc of the bundle that started the hold, replayed by the flush
  always_ff @(posedge cpu_clk_i) begin
    if (!in_hold && consume_i && mispredict) begin
      corr_pc_o <= vpc_i;
    end
  end

  // later mispredicts inside the hold never replace the replay pc
  a_corr_pc_held: assert property (@(posedge cpu_clk_i) disable iff (reset_i)
    in_hold |=> $stable(corr_pc_o));

endmodule

// File: run_sim.sh
#!/bin/sh
# build the decode stage testbench with Verilator and run it

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module decode_tb \
  -o decode_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/decode_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

echo "simulation passed"
exit 0

// File: slot_decoder.sv
// slot decoder: RV32I decode of one instruction word into scheduler fields and an exception
`timescale 1ns/1ns
module slot_decoder (
  input  decode_pkg::insn_t      insn_i,
  input  logic                   priv_i,
  input  logic                   tw_i,
  input  logic                   fetch_excp_vld_i,
  input  decode_pkg::excp_code_t fetch_excp_code_i,
  output logic                   port_o,
  output logic                   is_branch_o,
  output decode_pkg::alu_type_t  alu_type_o,
  output decode_pkg::alu_op_t    alu_op_o,
  output decode_pkg::ios_type_t  ios_type_o,
  output logic [2:0]             ios_op_o,
  output decode_pkg::special_t   special_o,
  output decode_pkg::reg_idx_t   rs1_o,
  output decode_pkg::reg_idx_t   rs2_o,
  output decode_pkg::reg_idx_t   dest_o,
  output decode_pkg::imm_t       imm_o,
  output decode_pkg::reg_props_t reg_props_o,
  output logic                   excp_vld_o,
  output decode_pkg::excp_code_t excp_code_o
);
  logic [4:0] opc;
  logic [2:0] f3;
  logic [6:0] f7;
  logic is_load, is_store, is_op, is_op_imm, is_bcc, is_jal, is_jalr;
  logic is_lui, is_auipc, is_system, is_misc_mem, is_fence, is_fence_i;
  logic is_ecall, is_ebreak, is_mret, is_wfi, is_csr;
  logic op_ok, op_imm_ok, legal, illegal, mret_trap, wfi_trap;
  decode_pkg::imm_t imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opc = insn_i[6:2];
  assign f3  = insn_i[14:12];
  assign f7  = insn_i[31:25];

  assign is_load     = opc == decode_pkg::OPC_LOAD;
  assign is_store    = opc == decode_pkg::OPC_STORE;
  assign is_op       = opc == decode_pkg::OPC_OP;
  assign is_op_imm   = opc == decode_pkg::OPC_OP_IMM;
  assign is_bcc      = opc == decode_pkg::OPC_BRANCH;
  assign is_jal      = opc == decode_pkg::OPC_JAL;
  assign is_jalr     = opc == decode_pkg::OPC_JALR;
  assign is_lui      = opc == decode_pkg::OPC_LUI;
  assign is_auipc    = opc == decode_pkg::OPC_AUIPC;
  assign is_system   = opc == decode_pkg::OPC_SYSTEM;
  assign is_misc_mem = opc == decode_pkg::OPC_MISC_MEM;
  assign is_fence    = is_misc_mem && f3 == 3'd0;
  assign is_fence_i  = is_misc_mem && f3 == 3'd1;

  // system encodings are matched on everything above the opcode
  assign is_ecall  = is_system && insn_i[31:7] == 25'h0000000;
  assign is_ebreak = is_system && insn_i[31:7] == 25'h0002000;
  assign is_mret   = is_system && insn_i[31:7] == 25'h0604000;
  assign is_wfi    = is_system && insn_i[31:7] == 25'h020a000;
  assign is_csr    = is_system && f3[1:0] != 2'b00;

  // sub/sra only for funct3 0 and 5
  assign op_ok = f7 == 7'd0 || (f7 == 7'b0100000 && (f3 == 3'd0 || f3 == 3'd5));
  always_comb begin
    op_imm_ok = 1'b1;
    if (f3 == 3'd1) begin
      op_imm_ok = f7 == 7'd0;
    end else if (f3 == 3'd5) begin
      op_imm_ok = f7 == 7'd0 || f7 == 7'b0100000;
    end
  end

  assign legal = insn_i[1:0] == 2'b11 &&
                 (is_lui || is_auipc || is_jal || is_misc_mem ||
                  (is_op && op_ok) || (is_op_imm && op_imm_ok) ||
                  (is_jalr && f3 == 3'd0) ||
                  (is_bcc && f3[2:1] != 2'b01) ||
                  (is_load && f3 != 3'd3 && f3[2:1] != 2'b11) ||
                  (is_store && f3 <= 3'd2) ||
                  is_ecall || is_ebreak || is_mret || is_wfi || is_csr);
  assign illegal = ~legal;

  assign port_o      = is_load | is_store | is_system | is_misc_mem;
  assign is_branch_o = is_jal | is_jalr | is_bcc;
  assign alu_type_o  = {is_op | is_op_imm, is_jal, is_jalr, is_lui, is_auipc};
  assign alu_op_o    = (is_op || (is_op_imm && f3 == 3'd5)) ? {insn_i[30], f3} : {1'b0, f3};
  assign ios_type_o  = {is_load, is_store, is_csr, is_fence};
  assign ios_op_o    = f3;
  assign special_o   = {is_csr & (insn_i[19:15] != 5'd0), is_mret, is_fence_i, is_wfi};
  assign rs1_o       = insn_i[19:15];
  assign rs2_o       = insn_i[24:20];
  assign dest_o      = insn_i[11:7];

  assign reg_props_o = {
    (is_op | is_op_imm | is_load | is_jal | is_jalr | is_auipc | is_lui | is_csr) &
      (insn_i[11:7] != 5'd0),
    ~(is_ecall | is_ebreak | is_mret | is_wfi | is_auipc | is_lui | is_jal),
    is_op | is_bcc | is_store
  };

  assign imm_i = {{20{insn_i[31]}}, insn_i[31:20]};
  assign imm_s = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
  assign imm_b = {{20{insn_i[31]}}, insn_i[7], insn_i[30:25], insn_i[11:8], 1'b0};
  assign imm_u = {insn_i[31:12], 12'h000};
  assign imm_j = {{12{insn_i[31]}}, insn_i[19:12], insn_i[20], insn_i[30:21], 1'b0};

  always_comb begin
    if (is_op_imm || is_jalr || is_load) begin
      imm_o = imm_i;
    end else if (is_system) begin
      // bit 12 tells the csr unit whether rs1/uimm is non-zero
      imm_o = {imm_i[31:13], insn_i[19:15] != 5'd0, imm_i[11:0]};
    end else if (is_store) begin
      imm_o = imm_s;
    end else if (is_lui || is_auipc) begin
      imm_o = imm_u;
    end else if (is_jal) begin
      imm_o = imm_j;
    end else if (is_bcc) begin
      imm_o = imm_b;
    end else begin
      imm_o = '0;
    end
  end

  // privilege checks, priv_i high is machine mode
  assign mret_trap = is_mret & ~priv_i;
  assign wfi_trap  = is_wfi & ~priv_i & tw_i;

  assign excp_vld_o = fetch_excp_vld_i | illegal | mret_trap | wfi_trap | is_ecall | is_ebreak;

  always_comb begin
    if (fetch_excp_vld_i) begin
      excp_code_o = fetch_excp_code_i;
    end else if (illegal || mret_trap || wfi_trap) begin
      excp_code_o = decode_pkg::EXC_ILLEGAL;
    end else if (is_ecall) begin
      excp_code_o = priv_i ? decode_pkg::EXC_ECALL_M : decode_pkg::EXC_ECALL_U;
    end else begin
      excp_code_o = decode_pkg::EXC_BREAKPOINT;
    end
  end

  // a word that raises no exception always lands in some scheduler class
  always_comb begin
    a_known_class: assert (excp_vld_o || alu_type_o != '0 || ios_type_o != '0 ||
                           is_branch_o || special_o != '0 || is_misc_mem);
  end

endmodule

// File: tb_clock_gen.sv
// testbench clock and reset generator: 100 ns clock, reset held for three cycles
`timescale 1ns/1ns
module tb_clock_gen (
  output logic cpu_clk_o,
  output logic reset_o
);
  initial begin
    cpu_clk_o = 1'b0;
    forever begin
      #50 cpu_clk_o = ~cpu_clk_o;
    end
  end

  initial begin
    reset_o = 1'b1;
    repeat (3) @(posedge cpu_clk_o);
    #10 reset_o = 1'b0;
  end

endmodule
